// File: datapath.f
+incdir+hdl
hdl/cpu_types_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/hazard_unit.sv
hdl/datapath.sv
verification/datapath_tb.sv

// File: hdl/cpu_config.svh
/* encodings for the supported MIPS subset; halt uses the reserved opcode 6'h3f
   the ALU codes fit alu_op_t and the forwarding selects fit fwd_sel_t */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define PC_INIT   32'h0000_0000

// major opcodes
`define OP_RTYPE  6'h00
`define OP_J      6'h02
`define OP_BEQ    6'h04
`define OP_BNE    6'h05
`define OP_ADDIU  6'h09
`define OP_ANDI   6'h0c
`define OP_ORI    6'h0d
`define OP_LUI    6'h0f
`define OP_LW     6'h23
`define OP_SW     6'h2b
`define OP_HALT   6'h3f

// function field of R-type
`define FN_ADDU   6'h21
`define FN_SUBU   6'h23
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_SLT    6'h2a

// ALU operations
`define ALU_ADD   3'd0
`define ALU_SUB   3'd1
`define ALU_AND   3'd2
`define ALU_OR    3'd3
`define ALU_SLT   3'd4
`define ALU_LUI   3'd5

// operand sources in EX
`define FWD_REG   2'd0
`define FWD_MEM   2'd1
`define FWD_WB    2'd2

`endif

// File: hdl/cpu_types_pkg.sv
/* types shared by the pipeline stages; a stage with valid low is a bubble
   and its other fields carry no meaning */
package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;
  typedef logic [2:0]  alu_op_t;
  typedef logic [1:0]  fwd_sel_t;

  typedef struct packed {
    logic  valid;
    word_t instruction;
    word_t pc_plus4;
  } if_id_t;

  typedef struct packed {
    logic     valid;
    regbits_t rs;
    regbits_t rt;
    regbits_t dest;
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm_ext;
    word_t    pc_plus4;
    word_t    jump_target;
    alu_op_t  alu_op;
    logic     alu_src;
    logic     is_branch;
    logic     branch_ne;
    logic     is_jump;
    logic     mem_read;
    logic     mem_write;
    logic     reg_wen;
    logic     halt;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    word_t    result;
    word_t    store_data;
    regbits_t dest;
    logic     mem_read;
    logic     mem_write;
    logic     reg_wen;
    logic     halt;
  } ex_mem_t;

  // register file write port, driven from MEM/WB
  typedef struct packed {
    logic     wen;
    regbits_t sel;
    word_t    data;
  } wb_t;

endpackage

// File: hdl/datapath.sv
/* five-stage core, both memory ports combinational with no wait states
   halt stays high until reset */
`timescale 1ns/1ps

module datapath (
  input  logic                 CLK,
  input  logic                 reset,
  output cpu_types_pkg::word_t imemaddr,
  input  cpu_types_pkg::word_t imemload,
  output cpu_types_pkg::word_t dmemaddr,
  output cpu_types_pkg::word_t dmemstore,
  output logic                 dmemwen,
  input  cpu_types_pkg::word_t dmemload,
  output logic                 halt
);
  import cpu_types_pkg::*;

  if_id_t   if_id;
  id_ex_t   id_ex;
  ex_mem_t  ex_mem;
  wb_t      wb;
  regbits_t rs_id;
  regbits_t rt_id;
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  word_t    redirect_pc;
  logic     stall;
  logic     redirect;

  fetch_stage fetch (
    .CLK(CLK), .reset(reset), .stall(stall), .redirect(redirect),
    .redirect_pc(redirect_pc), .imemaddr(imemaddr), .imemload(imemload),
    .if_id(if_id)
  );

  // a redirect from EX also flushes the ID/EX slot
  decode_stage decode (
    .CLK(CLK), .reset(reset), .if_id(if_id), .wb(wb), .stall(stall),
    .flush(redirect), .rs_id(rs_id), .rt_id(rt_id), .id_ex(id_ex)
  );

  execute_stage execute (
    .CLK(CLK), .reset(reset), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .wb(wb), .ex_mem(ex_mem), .redirect(redirect), .redirect_pc(redirect_pc)
  );

  memory_stage memory (
    .CLK(CLK), .reset(reset), .ex_mem(ex_mem), .dmemaddr(dmemaddr),
    .dmemstore(dmemstore), .dmemwen(dmemwen), .dmemload(dmemload),
    .wb(wb), .halt(halt)
  );

  hazard_unit hazard (
    .rs_id(rs_id), .rt_id(rt_id), .id_ex(id_ex), .ex_mem(ex_mem), .wb(wb),
    .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

endmodule

// File: hdl/decode_stage.sv
/* register file writes first and reads through, so WB to ID needs no stall
   unknown opcodes and function codes decode as a nop */
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_stage (
  input  logic                    CLK,
  input  logic                    reset,
  input  cpu_types_pkg::if_id_t   if_id,
  input  cpu_types_pkg::wb_t      wb,
  input  logic                    stall,
  input  logic                    flush,
  output cpu_types_pkg::regbits_t rs_id,
  output cpu_types_pkg::regbits_t rt_id,
  output cpu_types_pkg::id_ex_t   id_ex
);
  import cpu_types_pkg::*;

  word_t    instr;
  word_t    regs [32];
  word_t    rdat1;
  word_t    rdat2;
  word_t    sign_ext;
  regbits_t rd;
  logic [5:0]  opcode;
  logic [5:0]  funct;
  logic [15:0] imm;
  logic     wb_write;
  id_ex_t   dec;

  assign instr    = if_id.instruction;
  assign opcode   = instr[31:26];
  assign rs_id    = instr[25:21];
  assign rt_id    = instr[20:16];
  assign rd       = instr[15:11];
  assign funct    = instr[5:0];
  assign imm      = instr[15:0];
  assign sign_ext = {{16{imm[15]}}, imm};

  // register 0 is never written and stays zero
  assign wb_write = wb.wen && (wb.sel != '0);

  always_ff @(posedge CLK) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (wb_write) begin
      regs[wb.sel] <= wb.data;
    end
  end

  // read through the write in this cycle
  assign rdat1 = (wb_write && wb.sel == rs_id) ? wb.data : regs[rs_id];
  assign rdat2 = (wb_write && wb.sel == rt_id) ? wb.data : regs[rt_id];

  always_comb begin
    dec             = '0;
    dec.valid       = if_id.valid;
    dec.rs          = rs_id;
    dec.rt          = rt_id;
    dec.dest        = rt_id;
    dec.rdat1       = rdat1;
    dec.rdat2       = rdat2;
    dec.imm_ext     = sign_ext;
    dec.pc_plus4    = if_id.pc_plus4;
    dec.jump_target = {if_id.pc_plus4[31:28], instr[25:0], 2'b00};
    dec.alu_op      = `ALU_ADD;
    case (opcode)
      `OP_RTYPE: begin
        dec.dest    = rd;
        dec.reg_wen = 1'b1;
        case (funct)
          `FN_ADDU: dec.alu_op = `ALU_ADD;
          `FN_SUBU: dec.alu_op = `ALU_SUB;
          `FN_AND:  dec.alu_op = `ALU_AND;
          `FN_OR:   dec.alu_op = `ALU_OR;
          `FN_SLT:  dec.alu_op = `ALU_SLT;
          default:  dec.reg_wen = 1'b0;
        endcase
      end
      `OP_ADDIU: begin
        dec.alu_src = 1'b1;
        dec.reg_wen = 1'b1;
      end
      `OP_ANDI, `OP_ORI: begin
        dec.alu_op  = (opcode == `OP_ANDI) ? `ALU_AND : `ALU_OR;
        dec.alu_src = 1'b1;
        dec.reg_wen = 1'b1;
        dec.imm_ext = {16'h0000, imm};
      end
      `OP_LUI: begin
        dec.alu_op  = `ALU_LUI;
        dec.alu_src = 1'b1;
        dec.reg_wen = 1'b1;
        dec.imm_ext = {imm, 16'h0000};
      end
      `OP_LW: begin
        dec.alu_src  = 1'b1;
        dec.mem_read = 1'b1;
        dec.reg_wen  = 1'b1;
      end
      `OP_SW: begin
        dec.alu_src   = 1'b1;
        dec.mem_write = 1'b1;
      end
      `OP_BEQ:  dec.is_branch = 1'b1;
      `OP_BNE: begin
        dec.is_branch = 1'b1;
        dec.branch_ne = 1'b1;
      end
      `OP_J:    dec.is_jump = 1'b1;
      `OP_HALT: dec.halt = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex       <= dec;
      // bubble on load-use stall or on a redirect from EX
      id_ex.valid <= dec.valid & ~stall & ~flush;
    end
  end

endmodule

// File: hdl/execute_stage.sv
/* branches and jumps resolve here, so a taken one costs two squashed slots
   store data is the forwarded rt value, not the immediate */
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute_stage (
  input  logic                     CLK,
  input  logic                     reset,
  input  cpu_types_pkg::id_ex_t    id_ex,
  input  cpu_types_pkg::fwd_sel_t  fwd_a,
  input  cpu_types_pkg::fwd_sel_t  fwd_b,
  input  cpu_types_pkg::wb_t       wb,
  output cpu_types_pkg::ex_mem_t   ex_mem,
  output logic                     redirect,
  output cpu_types_pkg::word_t     redirect_pc
);
  import cpu_types_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t alu_b;
  word_t alu_result;
  word_t branch_target;
  logic  take_branch;

  function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                    input word_t mem_val, input word_t wb_val);
    case (sel)
      `FWD_MEM: return mem_val;
      `FWD_WB:  return wb_val;
      default:  return reg_val;
    endcase
  endfunction

  assign op_a  = fwd_mux(fwd_a, id_ex.rdat1, ex_mem.result, wb.data);
  assign op_b  = fwd_mux(fwd_b, id_ex.rdat2, ex_mem.result, wb.data);
  assign alu_b = id_ex.alu_src ? id_ex.imm_ext : op_b;

  always_comb begin
    case (id_ex.alu_op)
      `ALU_SUB: alu_result = op_a - alu_b;
      `ALU_AND: alu_result = op_a & alu_b;
      `ALU_OR:  alu_result = op_a | alu_b;
      `ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(alu_b)};
      // immediate already sits in the upper half
      `ALU_LUI: alu_result = alu_b;
      default:  alu_result = op_a + alu_b;
    endcase
  end

  assign branch_target = id_ex.pc_plus4 + {id_ex.imm_ext[29:0], 2'b00};
  assign take_branch   = id_ex.is_branch & ((op_a == op_b) ^ id_ex.branch_ne);
  assign redirect      = id_ex.valid & (id_ex.is_jump | take_branch);
  assign redirect_pc   = id_ex.is_jump ? id_ex.jump_target : branch_target;

  always_ff @(posedge CLK) begin
    if (reset) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem.valid <= id_ex.valid;
    end
  end

  always_ff @(posedge CLK) begin
    ex_mem.result     <= alu_result;
    ex_mem.store_data <= op_b;
    ex_mem.dest       <= id_ex.dest;
    ex_mem.mem_read   <= id_ex.mem_read;
    ex_mem.mem_write  <= id_ex.mem_write;
    ex_mem.reg_wen    <= id_ex.reg_wen;
    ex_mem.halt       <= id_ex.halt;
  end

endmodule

// File: hdl/fetch_stage.sv
/* instruction memory must answer in the same cycle as imemaddr
   a redirect from EX takes priority over a stall */
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_stage (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  stall,
  input  logic                  redirect,
  input  cpu_types_pkg::word_t  redirect_pc,
  output cpu_types_pkg::word_t  imemaddr,
  input  cpu_types_pkg::word_t  imemload,
  output cpu_types_pkg::if_id_t if_id
);
  import cpu_types_pkg::*;

  word_t pc;
  word_t pc_plus4;

  assign imemaddr = pc;
  assign pc_plus4 = pc + 32'd4;

  always_ff @(posedge CLK) begin
    if (reset) begin
      pc          <= `PC_INIT;
      if_id.valid <= 1'b0;
    end else if (redirect) begin
      // word fetched down the wrong path is dropped
      pc          <= redirect_pc;
      if_id.valid <= 1'b0;
    end else if (!stall) begin
      pc                <= pc_plus4;
      if_id.valid       <= 1'b1;
      if_id.instruction <= imemload;
      if_id.pc_plus4    <= pc_plus4;
    end
  end

endmodule

// File: hdl/hazard_unit.sv
/* stall is conservative, rt of ID is compared even when it is a destination
   a load in EX/MEM is never forwarded since the stall already covers it */
`timescale 1ns/1ps
`include "cpu_config.svh"

module hazard_unit (
  input  cpu_types_pkg::regbits_t rs_id,
  input  cpu_types_pkg::regbits_t rt_id,
  input  cpu_types_pkg::id_ex_t   id_ex,
  input  cpu_types_pkg::ex_mem_t  ex_mem,
  input  cpu_types_pkg::wb_t      wb,
  output logic                    stall,
  output cpu_types_pkg::fwd_sel_t fwd_a,
  output cpu_types_pkg::fwd_sel_t fwd_b
);
  import cpu_types_pkg::*;

  logic load_in_ex;
  logic mem_writes;
  logic wb_writes;

  // newest writer wins, EX/MEM before writeback
  function automatic fwd_sel_t pick_source(input regbits_t src,
                                           input logic mem_wr, input regbits_t mem_dest,
                                           input logic wb_wr, input regbits_t wb_dest);
    fwd_sel_t sel;
    sel = `FWD_REG;
    if (mem_wr && mem_dest == src) begin
      sel = `FWD_MEM;
    end else if (wb_wr && wb_dest == src) begin
      sel = `FWD_WB;
    end
    return sel;
  endfunction

  assign load_in_ex = id_ex.valid && id_ex.mem_read && (id_ex.dest != '0);
  assign stall      = load_in_ex && (id_ex.dest == rs_id || id_ex.dest == rt_id);

  assign mem_writes = ex_mem.valid && ex_mem.reg_wen && (ex_mem.dest != '0);
  assign wb_writes  = wb.wen && (wb.sel != '0);

  assign fwd_a = pick_source(id_ex.rs, mem_writes, ex_mem.dest, wb_writes, wb.sel);
  assign fwd_b = pick_source(id_ex.rt, mem_writes, ex_mem.dest, wb_writes, wb.sel);

endmodule

// File: hdl/memory_stage.sv
/* data memory must answer in the same cycle; halt is sticky until reset
   and blocks any store that follows it */
`timescale 1ns/1ps

module memory_stage (
  input  logic                   CLK,
  input  logic                   reset,
  input  cpu_types_pkg::ex_mem_t ex_mem,
  output cpu_types_pkg::word_t   dmemaddr,
  output cpu_types_pkg::word_t   dmemstore,
  output logic                   dmemwen,
  input  cpu_types_pkg::word_t   dmemload,
  output cpu_types_pkg::wb_t     wb,
  output logic                   halt
);
  import cpu_types_pkg::*;

  word_t wb_data;

  assign dmemaddr  = ex_mem.result;
  assign dmemstore = ex_mem.store_data;
  assign dmemwen   = ex_mem.valid & ex_mem.mem_write & ~halt;

  assign wb_data = ex_mem.mem_read ? dmemload : ex_mem.result;

  always_ff @(posedge CLK) begin
    if (reset) begin
      wb.wen <= 1'b0;
      halt   <= 1'b0;
    end else begin
      wb.wen <= ex_mem.valid & ex_mem.reg_wen;
      if (ex_mem.valid && ex_mem.halt) begin
        halt <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    wb.sel  <= ex_mem.dest;
    wb.data <= wb_data;
  end

endmodule

// File: verification/datapath_tb.sv
/* random program with forward branches only, checked against an ISA model
   both memories answer combinationally; the run stops at the first mismatch */
`timescale 1ns/1ps
`include "cpu_config.svh"

module datapath_tb;
  import cpu_types_pkg::*;

  localparam int PROG_LEN     = 200;
  localparam int RESET_CYCLES = 16;
  localparam int CLK_PERIOD   = 100;

  logic  CLK;
  logic  reset;
  logic  dmemwen;
  logic  halt;
  word_t imemaddr;
  word_t imemload;
  word_t dmemaddr;
  word_t dmemstore;
  word_t dmemload;

  word_t       prog [256];
  word_t       dmem [16];
  word_t       model_mem [16];
  word_t       exp_addr [$];
  word_t       exp_data [$];
  int          store_idx;
  logic [31:0] rng_state;

  datapath uut (
    .CLK(CLK), .reset(reset), .imemaddr(imemaddr), .imemload(imemload),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore), .dmemwen(dmemwen),
    .dmemload(dmemload), .halt(halt)
  );

  initial CLK = 1'b0;
  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // words past the program read as nop
  assign imemload = (imemaddr[31:10] == '0) ? prog[imemaddr[9:2]] : 32'h0;
  assign dmemload = dmem[dmemaddr[5:2]];

  always @(posedge CLK) begin
    if (dmemwen === 1'b1) begin
      dmem[dmemaddr[5:2]] <= dmemstore;
    end
  end

  function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // initial data window contents
  function automatic word_t fill_word(input int idx);
    word_t a;
    a = idx * 4;
    return {~a[15:0], a[15:0]} ^ 32'h5a5a_0000;
  endfunction

  function automatic word_t enc_r(input logic [5:0] fn, input regbits_t rs,
                                  input regbits_t rt, input regbits_t rd);
    return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t enc_i(input logic [5:0] op, input regbits_t rs,
                                  input regbits_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [5:0] pick_funct(input logic [2:0] sel);
    case (sel)
      3'd0, 3'd5: return `FN_ADDU;
      3'd1, 3'd6: return `FN_SUBU;
      3'd2:       return `FN_AND;
      3'd3:       return `FN_OR;
      default:    return `FN_SLT;
    endcase
  endfunction

  function automatic logic [5:0] pick_imm_op(input logic [1:0] sel);
    case (sel)
      2'd0:    return `OP_ADDIU;
      2'd1:    return `OP_ANDI;
      2'd2:    return `OP_ORI;
      default: return `OP_LUI;
    endcase
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED at %0t: %s expected %h actual %h",
                               $time, name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED at %0t: %s expected %b actual %b",
                               $time, name, expected, actual));
    end
  endtask

  task automatic build_program();
    int          i;
    int          kind;
    int          off;
    logic [31:0] r;
    logic [15:0] word_off;
    regbits_t    ra;
    regbits_t    rb;
    regbits_t    rc;
    for (i = 0; i < 256; i++) begin
      prog[i] = '0;
    end
    i = 0;
    while (i < PROG_LEN - 1) begin
      r        = next_rand();
      kind     = r[3:0];
      ra       = {2'b00, r[7:5]};
      rb       = {2'b00, r[10:8]};
      rc       = {2'b00, r[13:11]};
      word_off = {10'd0, r[19:16], 2'b00};
      off      = 1 + (r[15:14] % 3);
      // keep every target at or before the halt
      if (i + 1 + off > PROG_LEN - 1) begin
        off = PROG_LEN - 2 - i;
      end
      if (kind <= 6) begin
        prog[i] = enc_r(pick_funct(r[22:20]), ra, rb, rc);
      end else if (kind <= 8) begin
        prog[i] = enc_i(pick_imm_op(r[21:20]), ra, rb, r[31:16]);
      end else if (kind <= 10 && i < PROG_LEN - 2) begin
        prog[i] = enc_i(`OP_LW, 5'd0, rb, word_off);
        // consumer right behind the load
        if (r[23]) begin
          prog[i + 1] = enc_i(`OP_SW, 5'd0, rb, {10'd0, r[27:24], 2'b00});
        end else begin
          prog[i + 1] = enc_r(`FN_ADDU, rb, ra, rc);
        end
        i++;
      end else if (kind <= 12) begin
        prog[i] = enc_i(`OP_SW, 5'd0, rb, word_off);
      end else if (kind == 13) begin
        prog[i] = enc_i(`OP_BEQ, ra, rb, 16'(off));
      end else if (kind == 14) begin
        prog[i] = enc_i(`OP_BNE, ra, rb, 16'(off));
      end else begin
        prog[i] = {`OP_J, 26'(i + 1 + off)};
      end
      i++;
    end
    prog[i] = {`OP_HALT, 26'd0};
    // stores behind the halt must never reach the data port
    for (int k = 1; k <= 3; k++) begin
      prog[i + k] = enc_i(`OP_SW, 5'd0, regbits_t'(k), 16'(4 * k));
    end
  endtask

  // instruction-level execution, one instruction per step
  task automatic run_model();
    word_t      regs [32];
    word_t      pc;
    word_t      ins;
    word_t      next_pc;
    word_t      a;
    word_t      b;
    word_t      sext;
    word_t      zext;
    word_t      addr;
    regbits_t   rt;
    regbits_t   rd;
    int         steps;
    logic       done;
    for (int k = 0; k < 32; k++) begin
      regs[k] = '0;
    end
    pc    = `PC_INIT;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 4 * PROG_LEN) begin
      ins     = prog[pc[9:2]];
      rt      = ins[20:16];
      rd      = ins[15:11];
      a       = regs[ins[25:21]];
      b       = regs[rt];
      sext    = {{16{ins[15]}}, ins[15:0]};
      zext    = {16'h0000, ins[15:0]};
      addr    = a + sext;
      next_pc = pc + 32'd4;
      case (ins[31:26])
        `OP_RTYPE: begin
          case (ins[5:0])
            `FN_ADDU: regs[rd] = a + b;
            `FN_SUBU: regs[rd] = a - b;
            `FN_AND:  regs[rd] = a & b;
            `FN_OR:   regs[rd] = a | b;
            `FN_SLT:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: ;
          endcase
        end
        `OP_ADDIU: regs[rt] = a + sext;
        `OP_ANDI:  regs[rt] = a & zext;
        `OP_ORI:   regs[rt] = a | zext;
        `OP_LUI:   regs[rt] = {ins[15:0], 16'h0000};
        `OP_LW:    regs[rt] = model_mem[addr[5:2]];
        `OP_SW: begin
          model_mem[addr[5:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        `OP_BEQ: if (a == b) next_pc = pc + 32'd4 + {sext[29:0], 2'b00};
        `OP_BNE: if (a != b) next_pc = pc + 32'd4 + {sext[29:0], 2'b00};
        `OP_J:    next_pc = {next_pc[31:28], ins[25:0], 2'b00};
        `OP_HALT: done = 1'b1;
        default: ;
      endcase
      regs[0] = '0;
      pc      = next_pc;
      steps++;
    end
    if (!done) begin
      report_failure("the reference model never reached the halt instruction");
    end
  endtask

  // outputs held quiet during reset
  always @(negedge CLK) begin
    if (reset === 1'b1) begin
      check_bit("dmemwen", 1'b0, dmemwen);
      check_bit("halt", 1'b0, halt);
      check_word("imemaddr", `PC_INIT, imemaddr);
    end
  end

  // every store is compared in program order
  always @(negedge CLK) begin
    if (reset === 1'b0) begin
      if (halt === 1'b1) begin
        check_bit("dmemwen", 1'b0, dmemwen);
      end else if (dmemwen !== 1'b0) begin
        check_bit("dmemwen", 1'b1, dmemwen);
        if (store_idx >= exp_addr.size()) begin
          report_failure("the DUT stored more words than the program contains");
        end else begin
          check_word("dmemaddr", exp_addr[store_idx], dmemaddr);
          check_word("dmemstore", exp_data[store_idx], dmemstore);
          store_idx++;
        end
      end
    end
  end

  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + 20 * PROG_LEN));
    report_failure("timeout: halt never arrived");
  end

  initial begin
    reset     = 1'b1;
    rng_state = 32'h356;
    store_idx = 0;
    for (int k = 0; k < 16; k++) begin
      dmem[k]      = fill_word(k);
      model_mem[k] = fill_word(k);
    end
    build_program();
    run_model();
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 reset = 1'b0;
    // first cycle out of reset still fetches from the reset address
    @(negedge CLK);
    check_word("imemaddr", `PC_INIT, imemaddr);
    check_bit("dmemwen", 1'b0, dmemwen);
    check_bit("halt", 1'b0, halt);
    while (halt !== 1'b1) begin
      @(negedge CLK);
    end
    repeat (4) @(negedge CLK);
    check_word("store count", exp_addr.size(), store_idx);
    for (int k = 0; k < 16; k++) begin
      check_word($sformatf("dmem[%0d]", k), model_mem[k], dmem[k]);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule
